/* include/fpu_consts.svh */
// --------------------
// Widths, latency and sub-operation codes
// for the FP32 non-computational unit
// --------------------
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

`define FPU_FLEN          32  // Operand and result width
`define FPU_TRANS_ID_BITS 3   // Transaction tag width
`define FPU_NONCOMP_LAT   3   // Cycles from accept to result
`define FPU_LAT_BITS      2   // Occupancy counter width

// Sub-operations carried in the rm field
`define FPU_RM_SGNJ  3'b000
`define FPU_RM_SGNJN 3'b001
`define FPU_RM_SGNJX 3'b010
`define FPU_RM_PASS  3'b011   // Register move, no sign change
`define FPU_RM_MIN   3'b000
`define FPU_RM_MAX   3'b001
`define FPU_RM_LE    3'b000
`define FPU_RM_LT    3'b001
`define FPU_RM_EQ    3'b010

`endif

/* source/fpu_pkg.sv */
// --------------------
// Shared types of the FPU issue front end
// --------------------
`default_nettype none

`include "fpu_consts.svh"

package fpu_pkg;

    // --------------------
    // Plain vectors
    // --------------------
    typedef logic [`FPU_FLEN-1:0]          fp32_t;      // Single-precision operand or result
    typedef logic [`FPU_TRANS_ID_BITS-1:0] trans_id_t;  // Tag returned with the result
    typedef logic [4:0]                    status_t;    // NV DZ OF UF NX, MSB first
    typedef logic [2:0]                    sub_op_t;    // Sub-operation in the rm field
    typedef logic [`FPU_LAT_BITS-1:0]      lat_cnt_t;   // Occupancy countdown

    // --------------------
    // Enums
    // --------------------
    // Core-side operators
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,   // FPR to GPR
        FMV_X2F  = 3'd5    // GPR to FPR
    } fpu_oper_e;

    // Opcodes understood by the unit
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } noncomp_op_e;

    // Protocol inversion FSM
    typedef enum logic {
        READY = 1'b0,   // Upstream sees ready
        STALL = 1'b1    // Held instruction waits for the unit
    } issue_state_e;

endpackage

`default_nettype wire

/* source/fpu_op_decode.sv */
// --------------------
// Operator decoder: core operator and rm field
// to unit opcode and sub-operation
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fpu_op_decode
    import fpu_pkg::*;
(
    input  fpu_oper_e   operator_i,  // Operator from the core
    input  sub_op_t     rm_i,        // Raw rm field
    output noncomp_op_e op_o,        // Unit opcode
    output sub_op_t     sub_op_o     // Sub-operation for the unit
);

    // Low rm bits with the top bit masked
    sub_op_t rm_masked;

    assign rm_masked = {1'b0, rm_i[1:0]};

    always_comb begin : p_translate
        // Sign injection is the safe default
        op_o     = SGNJ;
        sub_op_o = `FPU_RM_SGNJ;

        case (operator_i)
            // Sign injection, variant in rm (000-010)
            FSGNJ: begin
                op_o     = SGNJ;
                sub_op_o = rm_masked;
            end
            // Min or max selected by rm[0]
            FMIN_MAX: begin
                op_o     = MINMAX;
                sub_op_o = rm_masked;
            end
            // le, lt, eq in rm
            FCMP: begin
                op_o     = CMP;
                sub_op_o = rm_masked;
            end
            FCLASS: begin
                op_o     = CLASSIFY;
                sub_op_o = rm_masked;  // Ignored by the unit
            end

            // Moves need no recoding, so they go through sign injection
            FMV_F2X: begin
                op_o     = SGNJ;
                sub_op_o = `FPU_RM_PASS;
            end
            FMV_X2F: begin
                op_o     = SGNJ;
                sub_op_o = `FPU_RM_PASS;
            end

            // Unknown encodings fall back to plain sign injection
            default: begin
                op_o     = SGNJ;
                sub_op_o = `FPU_RM_SGNJ;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/fpu_issue_fsm.sv */
// --------------------
// READY/STALL state machine for upstream protocol inversion and flush
// --------------------
`timescale 1ns/1ps
`default_nettype none

module fpu_issue_fsm
    import fpu_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic valid_i,       // Upstream valid
    input  logic unit_ready_i,  // Unit can take an instruction
    output logic ready_o,       // Upstream ready
    output logic unit_valid_o,  // Instruction offered to the unit
    output logic hold_o,        // Capture live instruction
    output logic use_hold_o     // Unit sees the held copy
);

    issue_state_e state_q, state_d;

    always_comb begin : p_next
        ready_o      = 1'b0;
        unit_valid_o = 1'b0;
        hold_o       = 1'b0;     // Hold register idle
        use_hold_o   = 1'b0;     // Live path by default
        state_d      = state_q;

        case (state_q)
            READY: begin
                ready_o      = 1'b1;     // Take whatever comes
                unit_valid_o = valid_i;  // Straight through to the unit
                // Park the instruction and stall upstream while the unit is busy
                if (valid_i && !unit_ready_i) begin
                    ready_o = 1'b0;
                    hold_o  = 1'b1;
                    state_d = STALL;
                end
            end
            STALL: begin
                unit_valid_o = 1'b1;
                use_hold_o   = 1'b1;
                if (unit_ready_i) begin
                    ready_o = 1'b1;   // Token back to the core
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        // Flush wins over everything
        if (flush_i) begin
            state_d = READY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // An offered instruction stays offered from the held copy until the unit takes it
    // or a flush drops it
    a_stall_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (unit_valid_o && !unit_ready_i && !flush_i)
            |=> (state_q == STALL && unit_valid_o && use_hold_o));

endmodule

`default_nettype wire

/* source/fpu_hold_reg.sv */
// --------------------
// Hold register for one decoded instruction,
// select between held copy and live inputs
// --------------------
`timescale 1ns/1ps
`default_nettype none

module fpu_hold_reg
    import fpu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        hold_i,       // Capture enable
    input  logic        use_hold_i,   // 1 selects the stored copy
    input  noncomp_op_e op_i,
    input  sub_op_t     sub_op_i,
    input  fp32_t       operand_a_i,
    input  fp32_t       operand_b_i,
    input  trans_id_t   trans_id_i,
    output noncomp_op_e op_o,
    output sub_op_t     sub_op_o,
    output fp32_t       operand_a_o,
    output fp32_t       operand_b_o,
    output trans_id_t   trans_id_o
);

    noncomp_op_e op_q;
    sub_op_t     sub_op_q;
    fp32_t       operand_a_q, operand_b_q;
    trans_id_t   trans_id_q;

    // Decoded control fields
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
        if (!rst_ni) begin
            op_q     <= SGNJ;
            sub_op_q <= '0;
        end else if (hold_i) begin
            op_q     <= op_i;
            sub_op_q <= sub_op_i;
        end
    end

    // Operands and tag
    always_ff @(posedge clk_i) begin : p_data
        if (hold_i) begin
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_i;
            trans_id_q  <= trans_id_i;
        end
    end

    assign op_o        = use_hold_i ? op_q        : op_i;
    assign sub_op_o    = use_hold_i ? sub_op_q    : sub_op_i;
    assign operand_a_o = use_hold_i ? operand_a_q : operand_a_i;
    assign operand_b_o = use_hold_i ? operand_b_q : operand_b_i;
    assign trans_id_o  = use_hold_i ? trans_id_q  : trans_id_i;

endmodule

`default_nettype wire

/* source/fpu_latency_timer.sv */
// --------------------
// Occupancy timer of the unit: ready, accept strobe, result valid
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fpu_latency_timer
    import fpu_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic in_valid_i,   // Instruction offered
    output logic in_ready_o,   // Idle, or finishing this cycle
    output logic start_o,      // Instruction taken
    output logic done_o        // Result valid pulse
);

    lat_cnt_t cnt_q;  // Zero means idle

    assign done_o     = (cnt_q == lat_cnt_t'(1)) && !flush_i;
    assign in_ready_o = (cnt_q == '0) || done_o;   // Back-to-back on the last cycle
    assign start_o    = in_valid_i && in_ready_o && !flush_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_count
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (flush_i) begin
            cnt_q <= '0;                               // Drop in-flight work
        end else if (start_o) begin
            cnt_q <= lat_cnt_t'(`FPU_NONCOMP_LAT);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - lat_cnt_t'(1);
        end
    end

    // Each result pulse traces back to an accept exactly one latency earlier
    a_done_after_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_o |-> $past(start_o, `FPU_NONCOMP_LAT));

endmodule

`default_nettype wire

/* source/fpu_noncomp_unit.sv */
// --------------------
// FP32 sign injection, min/max, compare, classify and move,
// with result, status and tag registers
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fpu_noncomp_unit
    import fpu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        start_i,      // Capture a new result
    input  noncomp_op_e op_i,
    input  sub_op_t     sub_op_i,
    input  fp32_t       operand_a_i,
    input  fp32_t       operand_b_i,
    input  trans_id_t   trans_id_i,
    output fp32_t       result_o,
    output status_t     status_o,     // Only NV can be set
    output trans_id_t   trans_id_o
);

    localparam fp32_t CANON_NAN = 32'h7fc0_0000;

    logic        a_sign, b_sign;
    logic [7:0]  a_exp, b_exp;
    logic [22:0] a_man, b_man;
    logic        a_zero, b_zero, a_sub, a_norm, a_inf;
    logic        a_nan, b_nan, a_snan, b_snan;
    logic        both_zero, any_nan, any_snan;
    logic        a_lt_b;      // -0 below +0
    logic        a_eq_b;      // -0 equals +0
    logic [9:0]  a_class;
    fp32_t       result_d;
    status_t     status_d;

    // --------------------
    // Field decode
    // --------------------
    assign {a_sign, a_exp, a_man} = operand_a_i;
    assign {b_sign, b_exp, b_man} = operand_b_i;

    assign a_zero = (a_exp == 8'h00) && (a_man == '0);
    assign b_zero = (b_exp == 8'h00) && (b_man == '0);
    assign a_sub  = (a_exp == 8'h00) && (a_man != '0);
    assign a_norm = (a_exp != 8'h00) && (a_exp != 8'hff);
    assign a_inf  = (a_exp == 8'hff) && (a_man == '0);
    assign a_nan  = (a_exp == 8'hff) && (a_man != '0);
    assign b_nan  = (b_exp == 8'hff) && (b_man != '0);
    assign a_snan = a_nan && !a_man[22];                   // Quiet bit clear
    assign b_snan = b_nan && !b_man[22];

    assign both_zero = a_zero && b_zero;
    assign any_nan   = a_nan || b_nan;
    assign any_snan  = a_snan || b_snan;

    // Sign-magnitude ordering, valid when neither is NaN
    always_comb begin : p_order
        if (a_sign != b_sign) begin
            a_lt_b = a_sign;
        end else if (a_sign) begin
            a_lt_b = operand_b_i[30:0] < operand_a_i[30:0];  // Both negative
        end else begin
            a_lt_b = operand_a_i[30:0] < operand_b_i[30:0];
        end
    end

    assign a_eq_b = (operand_a_i == operand_b_i) || both_zero;

    // RISC-V class, bit 0 is -inf
    assign a_class = {a_nan && !a_snan, a_snan,
                      !a_sign && a_inf,  !a_sign && a_norm,
                      !a_sign && a_sub,  !a_sign && a_zero,
                      a_sign && a_zero,  a_sign && a_sub,
                      a_sign && a_norm,  a_sign && a_inf};

    // --------------------
    // Operation select
    // --------------------
    always_comb begin : p_compute
        result_d = '0;
        status_d = '0;
        case (op_i)
            SGNJ: begin
                case (sub_op_i)
                    `FPU_RM_SGNJN: result_d = {!b_sign, operand_a_i[30:0]};
                    `FPU_RM_SGNJX: result_d = {a_sign ^ b_sign, operand_a_i[30:0]};
                    `FPU_RM_PASS:  result_d = operand_a_i;
                    default:       result_d = {b_sign, operand_a_i[30:0]};
                endcase
            end
            MINMAX: begin
                status_d[4] = any_snan;                    // NV
                if (a_nan && b_nan) begin
                    result_d = CANON_NAN;
                end else if (a_nan) begin
                    result_d = operand_b_i;                // Other input wins
                end else if (b_nan) begin
                    result_d = operand_a_i;
                end else if (sub_op_i == `FPU_RM_MAX) begin
                    result_d = a_lt_b ? operand_b_i : operand_a_i;
                end else begin
                    result_d = a_lt_b ? operand_a_i : operand_b_i;
                end
            end
            CMP: begin
                case (sub_op_i)
                    `FPU_RM_EQ: begin
                        status_d[4] = any_snan;           // Quiet compare
                        result_d[0] = !any_nan && a_eq_b;
                    end
                    `FPU_RM_LT: begin
                        status_d[4] = any_nan;            // Signaling compare
                        result_d[0] = !any_nan && a_lt_b && !both_zero;
                    end
                    `FPU_RM_LE: begin
                        status_d[4] = any_nan;
                        result_d[0] = !any_nan && ((a_lt_b && !both_zero) || a_eq_b);
                    end
                    default: result_d = '0;
                endcase
            end
            CLASSIFY: result_d = {{(`FPU_FLEN - 10){1'b0}}, a_class};
            default:  result_d = '0;
        endcase
    end

    // --------------------
    // Output registers, updated on start only
    // --------------------
    always_ff @(posedge clk_i) begin : p_result
        if (start_i) begin
            result_o   <= result_d;
            trans_id_o <= trans_id_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_status
        if (!rst_ni) begin
            status_o <= '0;
        end else if (start_i) begin
            status_o <= status_d;
        end
    end

    // Decoder and hold path must deliver a defined opcode on every accept
    a_op_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_i |-> !$isunknown(op_i));

endmodule

`default_nettype wire

/* source/fpu_wrap_top.sv */
// --------------------
// Top level of the FPU issue front end
// --------------------
`timescale 1ns/1ps
`default_nettype none

module fpu_wrap_top
    import fpu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    // Upstream, valid/ready
    input  logic      valid_i,
    output logic      ready_o,
    input  fpu_oper_e operator_i,
    input  sub_op_t   rm_i,
    input  fp32_t     operand_a_i,
    input  fp32_t     operand_b_i,
    input  trans_id_t trans_id_i,
    // Result side, always ready
    output logic      result_valid_o,
    output fp32_t     result_o,
    output status_t   status_o,
    output trans_id_t trans_id_o
);

    noncomp_op_e dec_op, sel_op;
    sub_op_t     dec_sub_op, sel_sub_op;
    fp32_t       sel_operand_a, sel_operand_b;
    trans_id_t   sel_trans_id;
    logic        hold, use_hold;
    logic        unit_valid, unit_ready, start;

    fpu_op_decode u_decode (
        .operator_i (operator_i),
        .rm_i       (rm_i),
        .op_o       (dec_op),
        .sub_op_o   (dec_sub_op)
    );

    fpu_issue_fsm u_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .valid_i      (valid_i),
        .unit_ready_i (unit_ready),
        .ready_o      (ready_o),
        .unit_valid_o (unit_valid),
        .hold_o       (hold),
        .use_hold_o   (use_hold)
    );

    fpu_hold_reg u_hold (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .hold_i      (hold),
        .use_hold_i  (use_hold),
        .op_i        (dec_op),
        .sub_op_i    (dec_sub_op),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .op_o        (sel_op),
        .sub_op_o    (sel_sub_op),
        .operand_a_o (sel_operand_a),
        .operand_b_o (sel_operand_b),
        .trans_id_o  (sel_trans_id)
    );

    // Result valid comes straight from the timer
    fpu_latency_timer u_timer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .in_valid_i (unit_valid),
        .in_ready_o (unit_ready),
        .start_o    (start),
        .done_o     (result_valid_o)
    );

    fpu_noncomp_unit u_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start),
        .op_i        (sel_op),
        .sub_op_i    (sel_sub_op),
        .operand_a_i (sel_operand_a),
        .operand_b_i (sel_operand_b),
        .trans_id_i  (sel_trans_id),
        .result_o    (result_o),
        .status_o    (status_o),
        .trans_id_o  (trans_id_o)
    );

endmodule

`default_nettype wire

/* test/tb_fpu_wrap.sv */
// --------------------
// Testbench of the FPU issue front end with stimulus, reference model,
// checking assertions, timeout and summary
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module tb_fpu_wrap
    import fpu_pkg::*;
();

    logic      clk_i;
    logic      rst_ni;
    logic      flush_i;
    logic      valid_i;
    logic      ready_o;
    fpu_oper_e operator_i;
    sub_op_t   rm_i;
    fp32_t     operand_a_i;
    fp32_t     operand_b_i;
    trans_id_t trans_id_i;
    logic      result_valid_o;
    fp32_t     result_o;
    status_t   status_o;
    trans_id_t trans_id_o;

    // --------------------
    // Scoreboard state
    // --------------------
    logic [36:0] exp_word [0:511];   // {status, result} per accepted instruction
    trans_id_t   exp_tag  [0:511];
    logic [8:0]  wr_ptr, rd_ptr;
    int          busy_cnt;           // Mirror of unit occupancy
    int          stall_cycles;       // Cycles with valid high and ready low
    int          cycles;
    int          err_value = 0;
    int          err_other = 0;
    int          seed = 32'hc444;
    trans_id_t   tag_cnt;
    logic        accept;
    fp32_t       exp_res_now;
    status_t     exp_status_now;
    trans_id_t   exp_tag_now;

    // +0 -0 +inf -inf qNaN sNaN +sub -sub +norm -norm
    fp32_t specials [0:9] = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
                              32'h7fc0_0000, 32'h7fa0_0000, 32'h0000_0001, 32'h807f_ffff,
                              32'h3f80_0000, 32'hc049_0fdb};

    assign accept         = valid_i && ready_o;
    assign exp_res_now    = exp_word[rd_ptr][31:0];
    assign exp_status_now = exp_word[rd_ptr][36:32];
    assign exp_tag_now    = exp_tag[rd_ptr];

    fpu_wrap_top DUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .valid_i        (valid_i),
        .ready_o        (ready_o),
        .operator_i     (operator_i),
        .rm_i           (rm_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .trans_id_i     (trans_id_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .status_o       (status_o),
        .trans_id_o     (trans_id_o)
    );

    always #5 clk_i = ~clk_i;   // 10 ns period

    // --------------------
    // Reference model
    // --------------------
    // One-hot RISC-V class with -inf in bit 0
    function automatic logic [9:0] fp_class(input fp32_t x);
        if (x[30:23] == 8'hff && x[22:0] != '0) return x[22] ? 10'h200 : 10'h100;
        if (x[30:23] == 8'hff) return x[31] ? 10'h001 : 10'h080;
        if (x[30:0] == '0) return x[31] ? 10'h008 : 10'h010;
        if (x[30:23] == 8'h00) return x[31] ? 10'h004 : 10'h020;
        return x[31] ? 10'h002 : 10'h040;
    endfunction

    // Total order key with -0 just below +0
    function automatic longint order_key(input fp32_t x);
        if (x[31]) return -longint'(x[30:0]) - 1;
        return longint'(x[30:0]);
    endfunction

    function automatic logic [36:0] model(input fpu_oper_e op, input sub_op_t rm,
                                          input fp32_t a, input fp32_t b);
        logic [1:0] sub;
        logic       nan_a;
        logic       nan_b;
        logic       snan_any;
        logic       zeros;
        longint     ka;
        longint     kb;
        fp32_t      res;
        logic       nv;
        sub      = rm[1:0];            // Top rm bit is ignored
        nan_a    = (fp_class(a) & 10'h300) != '0;
        nan_b    = (fp_class(b) & 10'h300) != '0;
        snan_any = (fp_class(a) == 10'h100) || (fp_class(b) == 10'h100);
        zeros    = (a[30:0] == '0) && (b[30:0] == '0);
        ka       = order_key(a);
        kb       = order_key(b);
        res      = '0;
        nv       = 1'b0;
        case (op)
            FSGNJ: begin
                case (sub)
                    2'd0:    res = {b[31], a[30:0]};
                    2'd1:    res = {~b[31], a[30:0]};
                    2'd2:    res = {a[31] ^ b[31], a[30:0]};
                    default: res = a;      // Passthrough code
                endcase
            end
            FMIN_MAX: begin
                nv = snan_any;
                if (nan_a && nan_b) res = 32'h7fc0_0000;
                else if (nan_a) res = b;
                else if (nan_b) res = a;
                else if (sub == 2'd1) res = (ka > kb) ? a : b;
                else res = (ka < kb) ? a : b;
            end
            FCMP: begin
                if (sub == 2'd2) begin
                    nv     = snan_any;    // Quiet equal
                    res[0] = !nan_a && !nan_b && (a == b || zeros);
                end else if (sub == 2'd1) begin
                    nv     = nan_a || nan_b;
                    res[0] = !nan_a && !nan_b && !zeros && (ka < kb);
                end else if (sub == 2'd0) begin
                    nv     = nan_a || nan_b;
                    res[0] = !nan_a && !nan_b && (zeros || ka <= kb);
                end
            end
            FCLASS:  res = {22'b0, fp_class(a)};
            default: res = a;              // Both moves
        endcase
        return {nv, 4'b0000, res};
    endfunction

    // --------------------
    // Scoreboard and occupancy mirror
    // --------------------
    always @(posedge clk_i or negedge rst_ni) begin : track
        if (!rst_ni) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            busy_cnt     <= 0;
            stall_cycles <= 0;
        end else begin
            if (accept) begin
                exp_word[wr_ptr] <= model(operator_i, rm_i, operand_a_i, operand_b_i);
                exp_tag[wr_ptr]  <= trans_id_i;
                wr_ptr           <= wr_ptr + 9'd1;
            end
            if (flush_i) rd_ptr <= wr_ptr;             // Pending work is dropped
            else if (result_valid_o) rd_ptr <= rd_ptr + 9'd1;
            if (flush_i) busy_cnt <= 0;
            else if (accept) busy_cnt <= `FPU_NONCOMP_LAT;
            else if (busy_cnt > 0) busy_cnt <= busy_cnt - 1;
            if (valid_i && !ready_o) stall_cycles <= stall_cycles + 1;
        end
    end

    // --------------------
    // Checking assertions
    // --------------------
    a_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_o |-> result_o == exp_res_now)
        else begin
            err_value++;
            $display("Fail t=%0t result_o expected %h got %h", $time,
                     $sampled(exp_res_now), $sampled(result_o));
        end

    a_status: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_o |-> status_o == exp_status_now)
        else begin
            err_value++;
            $display("Fail t=%0t status_o expected %b got %b", $time,
                     $sampled(exp_status_now), $sampled(status_o));
        end

    a_tag: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_o |-> trans_id_o == exp_tag_now)
        else begin
            err_value++;
            $display("Fail t=%0t trans_id_o expected %0d got %0d", $time,
                     $sampled(exp_tag_now), $sampled(trans_id_o));
        end

    a_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_o |-> rd_ptr != wr_ptr)
        else begin
            err_other++;
            $display("Result returned with no instruction pending at t=%0t", $time);
        end

    // Nothing happens before the first accept
    a_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wr_ptr == '0) |-> ready_o && !result_valid_o)
        else begin
            err_other++;
            $display("Not idle and ready after reset at t=%0t", $time);
        end

    a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
        accept |-> ##(`FPU_NONCOMP_LAT) result_valid_o)
        else begin
            err_other++;
            $display("Result missing %0d cycles after accept, t=%0t", `FPU_NONCOMP_LAT, $time);
        end

    a_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_o |=> !result_valid_o ##1 !result_valid_o)
        else begin
            err_other++;
            $display("Result pulses closer than the unit latency at t=%0t", $time);
        end

    // Ready follows the occupancy of the unit
    a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i && !flush_i) |-> ready_o == (busy_cnt <= 1))
        else begin
            err_value++;
            $display("Fail t=%0t ready_o expected %b got %b", $time,
                     $sampled(busy_cnt <= 1), $sampled(ready_o));
        end

    a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !result_valid_o ##1 !result_valid_o ##1 !result_valid_o)
        else begin
            err_other++;
            $display("Result appeared for flushed work at t=%0t", $time);
        end

    a_flush_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> ready_o)
        else begin
            err_other++;
            $display("Not ready in the cycle after a flush, t=%0t", $time);
        end

    // --------------------
    // Stimulus
    // --------------------
    // Presents one instruction from a rising edge and returns on its accepting edge
    task automatic issue(input fpu_oper_e op, input sub_op_t rm, input fp32_t a, input fp32_t b);
        logic taken;
        taken = 1'b0;
        valid_i     <= 1'b1;
        operator_i  <= op;
        rm_i        <= rm;
        operand_a_i <= a;
        operand_b_i <= b;
        trans_id_i  <= tag_cnt;
        tag_cnt = tag_cnt + 3'd1;
        while (!taken) begin
            @(negedge clk_i);
            taken = ready_o;   // Stable mid-cycle
            @(posedge clk_i);
        end
    endtask

    task automatic idle(input int n);
        valid_i <= 1'b0;
        repeat (n) @(posedge clk_i);
    endtask

    always @(posedge clk_i) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin : stimulus
        int    j;
        fp32_t ra;
        fp32_t rb;
        clk_i        = 1'b0;
        rst_ni      <= 1'b0;
        flush_i     <= 1'b0;
        valid_i     <= 1'b0;
        operator_i  <= FSGNJ;
        rm_i        <= '0;
        operand_a_i <= '0;
        operand_b_i <= '0;
        trans_id_i  <= '0;
        tag_cnt      = '0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        idle(3);

        // Sign injection with gaps that leave some accepts on an idle unit
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < 4; i++) begin
                issue(FSGNJ, sub_op_t'(r), $random(seed), $random(seed));
            end
            idle(4);
        end
        issue(FMV_F2X, 3'd0, $random(seed), $random(seed));
        issue(FMV_X2F, 3'd5, specials[5], specials[1]);
        idle(4);

        // Min/max and compare over special pairs including NaN pairs and both zeros
        for (int i = 0; i < 10; i++) begin
            for (int k = 0; k < 2; k++) begin
                j = (i + 5 * k + 1) % 10;
                issue(FMIN_MAX, `FPU_RM_MIN, specials[i], specials[j]);
                issue(FMIN_MAX, `FPU_RM_MAX, specials[i], specials[j]);
                issue(FCMP, `FPU_RM_LE, specials[i], specials[j]);
                issue(FCMP, `FPU_RM_LT, specials[i], specials[j]);
                issue(FCMP, `FPU_RM_EQ, specials[i], specials[j]);
            end
        end
        for (int i = 0; i < 8; i++) begin
            ra = $random(seed);
            rb = (i % 2 == 1) ? ra ^ 32'h1 : $random(seed);   // Near-equal pairs too
            issue(FMIN_MAX, `FPU_RM_MIN, ra, rb);
            issue(FMIN_MAX, `FPU_RM_MAX, ra, rb);
            issue(FCMP, `FPU_RM_LE, ra, rb);
            issue(FCMP, `FPU_RM_LT, rb, ra);
            issue(FCMP, 3'b110, ra, ra);    // EQ with the top rm bit set
        end

        // Classify
        for (int i = 0; i < 10; i++) begin
            issue(FCLASS, 3'd0, specials[i], $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            issue(FCLASS, 3'd0, $random(seed), '0);
        end
        idle(6);

        // Flush with one in flight and one held
        issue(FSGNJ, `FPU_RM_SGNJN, specials[8], specials[0]);
        valid_i     <= 1'b1;
        operator_i  <= FCLASS;
        operand_a_i <= specials[2];
        trans_id_i  <= tag_cnt;
        @(posedge clk_i);
        flush_i <= 1'b1;
        valid_i <= 1'b0;
        @(posedge clk_i);
        flush_i <= 1'b0;
        issue(FSGNJ, `FPU_RM_SGNJX, specials[9], specials[3]);
        idle(8);

        if (rd_ptr != wr_ptr) begin
            err_other++;
            $display("Instructions lost, %0d results still missing", wr_ptr - rd_ptr);
        end
        if (stall_cycles == 0) begin
            err_other++;
            $display("Back-pressure never occurred");
        end
        $display("Summary: %0d value errors, %0d other errors", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
source/fpu_pkg.sv
source/fpu_op_decode.sv
source/fpu_issue_fsm.sv
source/fpu_hold_reg.sv
source/fpu_latency_timer.sv
source/fpu_noncomp_unit.sv
source/fpu_wrap_top.sv
test/tb_fpu_wrap.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f tb.f --top-module tb_fpu_wrap -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi
